//--- b200_regs_pkg.sv
// Settings bus and register map for the board-control block
// Widths, addresses and the clock hold-off length

package b200_regs_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Settings bus
   ////////////////////////////////////////////////////////////////////////////

   localparam int unsigned set_addr_w = 8;   // Host register address width
   localparam int unsigned set_data_w = 32;  // Host write data width

   ////////////////////////////////////////////////////////////////////////////
   // Register map
   ////////////////////////////////////////////////////////////////////////////

   // Misc outputs word, low 9 bits go to pins
   localparam logic [set_addr_w-1:0] reg_misc_outs = 8'h00;

   // Start of the per-radio ATR windows
   // Radio r owns base + 4*r up to base + 4*r + 3
   localparam logic [set_addr_w-1:0] reg_atr_base = 8'h10;

   // Address step between radios
   // The low two bits pick the ATR state, same code as atr_state_t
   localparam int unsigned reg_atr_stride = 4;

   ////////////////////////////////////////////////////////////////////////////
   // Clock hold-off
   ////////////////////////////////////////////////////////////////////////////

   // Counter width, hold-off is 2**holdoff_bits bus clocks
   // Board build counts much longer, short here to keep sims quick
   localparam int unsigned holdoff_bits = 4;

endpackage : b200_regs_pkg

//--- b200_fe_pkg.sv
// Frontend definitions for the two-radio board
// ATR state code and pin positions inside ATR and misc words

package b200_fe_pkg;

   localparam int unsigned n_radios = 2;  // Radios on the board
   localparam int unsigned atr_w    = 8;  // Bits per ATR control word

   // Radio activity, value doubles as ATR register offset
   typedef enum logic [1:0] {
      idle        = 2'd0,
      rx_only     = 2'd1,
      tx_only     = 2'd2,
      full_duplex = 2'd3
   } atr_state_t;

   // ATR word layout, msb first
   localparam int unsigned fe_bit_tx_enable   = 7;
   localparam int unsigned fe_bit_sfdx_rx     = 6;  // Full duplex switch, rx side
   localparam int unsigned fe_bit_sfdx_tx     = 5;
   localparam int unsigned fe_bit_srx_rx      = 4;  // Rx-only switch
   localparam int unsigned fe_bit_srx_tx      = 3;
   localparam int unsigned fe_bit_led_rx      = 2;
   localparam int unsigned fe_bit_led_txrx_rx = 1;
   localparam int unsigned fe_bit_led_txrx_tx = 0;

   // Misc outputs layout
   localparam int unsigned misc_bit_swap_atr_n   = 8;  // Low swaps radios onto frontends
   localparam int unsigned misc_bit_tx_bandsel_a = 7;
   localparam int unsigned misc_bit_tx_bandsel_b = 6;
   localparam int unsigned misc_bit_rx_bandsel_a = 5;
   localparam int unsigned misc_bit_rx_bandsel_b = 4;
   localparam int unsigned misc_bit_rx_bandsel_c = 3;
   localparam int unsigned misc_bit_spare        = 2;  // Free for reuse
   localparam int unsigned misc_bit_mimo         = 1;
   localparam int unsigned misc_bit_ref_sel      = 0;

endpackage : b200_fe_pkg

//--- clocks_ready_reset.sv
// Clock-stable hold-off and bus reset generation
// Keeps bus_rst high until the clock generator has been locked for a while

`timescale 1ns/1ps

module clocks_ready_reset (
   input  logic bus_clk,
   input  logic reset_global,
   input  logic locked,       // Clock generator lock level
   output logic bus_rst
);

   import b200_regs_pkg::*;

   logic [holdoff_bits-1:0] ready_count;  // Hold-off counter
   logic                    clocks_ready;
   logic [1:0]              rst_sync;     // Release synchronizer

   ////////////////////////////////////////////////////////////////////////////
   // Hold-off counter
   ////////////////////////////////////////////////////////////////////////////

   // Cleared at once by global reset or loss of lock
   always_ff @(posedge bus_clk or posedge reset_global or negedge locked) begin
      if (reset_global || !locked) begin
         ready_count  <= '0;
         clocks_ready <= 1'b0;
      end else if (!clocks_ready) begin
         ready_count  <= ready_count + 1'b1;
         clocks_ready <= (ready_count == '1);  // Set on the last count
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Reset synchronizer
   ////////////////////////////////////////////////////////////////////////////

   // Asserts as soon as clocks_ready drops
   // Releases two bus clocks after clocks_ready rises
   always_ff @(posedge bus_clk or negedge clocks_ready) begin
      if (!clocks_ready) begin
         rst_sync <= 2'b11;
      end else begin
         rst_sync <= {rst_sync[0], 1'b0};
      end
   end

   assign bus_rst = rst_sync[1];

   // Design must never run on an unlocked clock
   a_rst_when_unlocked : assert property (
      @(posedge bus_clk) !locked |-> bus_rst
   ) else $error("bus_rst low while clock generator unlocked");

endmodule : clocks_ready_reset

//--- settings_regs.sv
// Host settings register bank
// Holds the misc outputs word and four ATR words per radio

`timescale 1ns/1ps

module settings_regs (
   input  logic                                  bus_clk,
   input  logic                                  bus_rst,
   input  logic                                  set_stb,   // One-cycle write strobe
   input  logic [b200_regs_pkg::set_addr_w-1:0] set_addr,
   input  logic [b200_regs_pkg::set_data_w-1:0] set_data,
   output logic [b200_regs_pkg::set_data_w-1:0] misc_outs,
   output logic [b200_fe_pkg::atr_w-1:0]        atr_idle [b200_fe_pkg::n_radios],
   output logic [b200_fe_pkg::atr_w-1:0]        atr_rx   [b200_fe_pkg::n_radios],
   output logic [b200_fe_pkg::atr_w-1:0]        atr_tx   [b200_fe_pkg::n_radios],
   output logic [b200_fe_pkg::atr_w-1:0]        atr_fdx  [b200_fe_pkg::n_radios]
);

   import b200_regs_pkg::*;
   import b200_fe_pkg::*;

   // Size of all ATR windows together
   localparam logic [set_addr_w-1:0] atr_span = set_addr_w'(n_radios * reg_atr_stride);

   logic [set_addr_w-1:0] atr_off;    // Address relative to the ATR base
   logic                  atr_hit;    // Address lands in some radio's window
   logic [set_addr_w-3:0] atr_radio;  // Which radio
   atr_state_t            atr_state;  // Which of the four words

   ////////////////////////////////////////////////////////////////////////////
   // Address decode
   ////////////////////////////////////////////////////////////////////////////

   assign atr_off   = set_addr - reg_atr_base;
   assign atr_hit   = (set_addr >= reg_atr_base) && (atr_off < atr_span);
   assign atr_radio = atr_off[set_addr_w-1:2];            // Stride of four words
   assign atr_state = atr_state_t'(atr_off[1:0]);

   ////////////////////////////////////////////////////////////////////////////
   // Register writes
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge bus_clk or posedge bus_rst) begin
      if (bus_rst) begin
         misc_outs <= '0;
         for (int r = 0; r < n_radios; r++) begin
            atr_idle[r] <= '0;
            atr_rx[r]   <= '0;
            atr_tx[r]   <= '0;
            atr_fdx[r]  <= '0;
         end
      end else if (set_stb) begin
         if (set_addr == reg_misc_outs) begin
            misc_outs <= set_data;  // Full word kept
         end
         // Only the low ATR bits are stored
         for (int r = 0; r < n_radios; r++) begin
            if (atr_hit && (atr_radio == (set_addr_w-2)'(r))) begin
               case (atr_state)
                  idle:        atr_idle[r] <= set_data[atr_w-1:0];
                  rx_only:     atr_rx[r]   <= set_data[atr_w-1:0];
                  tx_only:     atr_tx[r]   <= set_data[atr_w-1:0];
                  full_duplex: atr_fdx[r]  <= set_data[atr_w-1:0];
                  default:     ;
               endcase
            end
         end
      end
      // Anything else on the bus is dropped
   end

   // An X address would silently miss every register
   a_addr_known : assert property (
      @(posedge bus_clk) disable iff (bus_rst)
      set_stb |-> !$isunknown(set_addr)
   ) else $error("Unknown set_addr during settings write");

endmodule : settings_regs

//--- radio_atr_ctrl.sv
// Per-radio ATR control
// Picks one of four programmed frontend words from the run levels

`timescale 1ns/1ps

module radio_atr_ctrl (
   input  logic                           bus_clk,
   input  logic                           bus_rst,
   input  logic                           run_rx,    // Receive chain active
   input  logic                           run_tx,    // Transmit chain active
   input  logic [b200_fe_pkg::atr_w-1:0] atr_idle,
   input  logic [b200_fe_pkg::atr_w-1:0] atr_rx,
   input  logic [b200_fe_pkg::atr_w-1:0] atr_tx,
   input  logic [b200_fe_pkg::atr_w-1:0] atr_fdx,
   output logic [b200_fe_pkg::atr_w-1:0] atr        // Word for the current state
);

   import b200_fe_pkg::*;

   atr_state_t state;

   ////////////////////////////////////////////////////////////////////////////
   // State from run levels
   ////////////////////////////////////////////////////////////////////////////

   // Tx in the upper bit, rx in the lower
   assign state = atr_state_t'({run_tx, run_rx});

   ////////////////////////////////////////////////////////////////////////////
   // Output word
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge bus_clk or posedge bus_rst) begin
      if (bus_rst) begin
         atr <= '0;  // All switches and LEDs off
      end else begin
         case (state)
            idle:        atr <= atr_idle;
            rx_only:     atr <= atr_rx;
            tx_only:     atr <= atr_tx;
            full_duplex: atr <= atr_fdx;
            default:     atr <= atr_idle;
         endcase
      end
   end

   // Never drive a word the host did not program
   a_atr_programmed : assert property (
      @(posedge bus_clk) disable iff (bus_rst)
      $past(!bus_rst) |->
         (atr == $past(atr_idle)) || (atr == $past(atr_rx)) ||
         (atr == $past(atr_tx))   || (atr == $past(atr_fdx))
   ) else $error("ATR output is not one of the programmed words");

endmodule : radio_atr_ctrl

//--- frontend_atr_mux.sv
// Frontend pin stage
// Maps the radios onto the two frontends and decodes the misc outputs word

`timescale 1ns/1ps

module frontend_atr_mux (
   input  logic                                  bus_clk,
   input  logic                                  bus_rst,
   input  logic [b200_regs_pkg::set_data_w-1:0] misc_outs,
   input  logic [b200_fe_pkg::atr_w-1:0]        radio_atr [b200_fe_pkg::n_radios],
   output logic [b200_fe_pkg::atr_w-1:0]        fe1_ctrl,
   output logic [b200_fe_pkg::atr_w-1:0]        fe2_ctrl,
   output logic                                  tx_bandsel_a,
   output logic                                  tx_bandsel_b,
   output logic                                  rx_bandsel_a,
   output logic                                  rx_bandsel_b,
   output logic                                  rx_bandsel_c,
   output logic                                  mimo,
   output logic                                  ref_sel
);

   import b200_regs_pkg::*;
   import b200_fe_pkg::*;

   logic [set_data_w-1:0] misc_r;      // Misc word near the pins
   logic                  swap_atr_n;

   ////////////////////////////////////////////////////////////////////////////
   // Misc register stage
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge bus_clk or posedge bus_rst) begin
      if (bus_rst) begin
         misc_r <= '0;
      end else begin
         misc_r <= misc_outs;  // Eases routing to the IO flops
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Radio to frontend mapping
   ////////////////////////////////////////////////////////////////////////////

   // Most boards have radio 0 wired to frontend 2
   assign swap_atr_n = misc_r[misc_bit_swap_atr_n];

   assign fe1_ctrl = swap_atr_n ? radio_atr[0] : radio_atr[1];
   assign fe2_ctrl = swap_atr_n ? radio_atr[1] : radio_atr[0];

   // Band selects and board controls
   assign tx_bandsel_a = misc_r[misc_bit_tx_bandsel_a];
   assign tx_bandsel_b = misc_r[misc_bit_tx_bandsel_b];
   assign rx_bandsel_a = misc_r[misc_bit_rx_bandsel_a];
   assign rx_bandsel_b = misc_r[misc_bit_rx_bandsel_b];
   assign rx_bandsel_c = misc_r[misc_bit_rx_bandsel_c];
   assign mimo         = misc_r[misc_bit_mimo];     // Both codec channels in use
   assign ref_sel      = misc_r[misc_bit_ref_sel];  // Reference clock source

endmodule : frontend_atr_mux

//--- b200_fe_ctrl.sv
// Board control top level
// Reset hold-off, host settings, per-radio ATR and frontend pin mapping

`timescale 1ns/1ps

module b200_fe_ctrl (
   input  logic                                  bus_clk,       // 100 MHz bus clock
   input  logic                                  reset_global,
   input  logic                                  locked,        // Clock generator locked
   input  logic                                  set_stb,
   input  logic [b200_regs_pkg::set_addr_w-1:0] set_addr,
   input  logic [b200_regs_pkg::set_data_w-1:0] set_data,
   input  logic [b200_fe_pkg::n_radios-1:0]     run_rx,
   input  logic [b200_fe_pkg::n_radios-1:0]     run_tx,
   output logic                                  ready,
   output logic                                  codec_reset,   // Active low at the codec
   output logic [b200_fe_pkg::atr_w-1:0]        fe1_ctrl,
   output logic [b200_fe_pkg::atr_w-1:0]        fe2_ctrl,
   output logic                                  tx_bandsel_a,
   output logic                                  tx_bandsel_b,
   output logic                                  rx_bandsel_a,
   output logic                                  rx_bandsel_b,
   output logic                                  rx_bandsel_c,
   output logic                                  mimo,
   output logic                                  ref_sel
);

   import b200_regs_pkg::*;
   import b200_fe_pkg::*;

   logic                  bus_rst;
   logic [set_data_w-1:0] misc_outs;
   logic [atr_w-1:0]      atr_idle  [n_radios];
   logic [atr_w-1:0]      atr_rx    [n_radios];
   logic [atr_w-1:0]      atr_tx    [n_radios];
   logic [atr_w-1:0]      atr_fdx   [n_radios];
   logic [atr_w-1:0]      radio_atr [n_radios];  // Per-radio frontend word

   assign ready       = !bus_rst;
   assign codec_reset = !reset_global;

   clocks_ready_reset clocks_ready_reset_i (
      .bus_clk      (bus_clk),
      .reset_global (reset_global),
      .locked       (locked),
      .bus_rst      (bus_rst)
   );

   settings_regs settings_regs_i (
      .bus_clk   (bus_clk),
      .bus_rst   (bus_rst),
      .set_stb   (set_stb),
      .set_addr  (set_addr),
      .set_data  (set_data),
      .misc_outs (misc_outs),
      .atr_idle  (atr_idle),
      .atr_rx    (atr_rx),
      .atr_tx    (atr_tx),
      .atr_fdx   (atr_fdx)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Radios
   ////////////////////////////////////////////////////////////////////////////

   for (genvar i = 0; i < n_radios; i++) begin : radio_i
      radio_atr_ctrl radio_atr_ctrl_i (
         .bus_clk  (bus_clk),
         .bus_rst  (bus_rst),
         .run_rx   (run_rx[i]),
         .run_tx   (run_tx[i]),
         .atr_idle (atr_idle[i]),
         .atr_rx   (atr_rx[i]),
         .atr_tx   (atr_tx[i]),
         .atr_fdx  (atr_fdx[i]),
         .atr      (radio_atr[i])
      );
   end

   frontend_atr_mux frontend_atr_mux_i (
      .bus_clk      (bus_clk),
      .bus_rst      (bus_rst),
      .misc_outs    (misc_outs),
      .radio_atr    (radio_atr),
      .fe1_ctrl     (fe1_ctrl),
      .fe2_ctrl     (fe2_ctrl),
      .tx_bandsel_a (tx_bandsel_a),
      .tx_bandsel_b (tx_bandsel_b),
      .rx_bandsel_a (rx_bandsel_a),
      .rx_bandsel_b (rx_bandsel_b),
      .rx_bandsel_c (rx_bandsel_c),
      .mimo         (mimo),
      .ref_sel      (ref_sel)
   );

endmodule : b200_fe_ctrl

//--- tb_b200_fe_ctrl.sv
// Testbench for the board-control top level
// Shadow register model with the fixed pipeline delays, checked by concurrent assertions

`timescale 1ns/1ps

module tb_b200_fe_ctrl;

   import b200_regs_pkg::*;
   import b200_fe_pkg::*;

   localparam int ready_timeout = 64;                          // Bus clocks per wait
   localparam int ready_delay   = int'(1 << holdoff_bits) + 2;  // Hold-off plus synchronizer
   localparam int atr_words     = 4 * int'(n_radios);           // All ATR windows

   logic                  bus_clk;
   logic                  reset_global;
   logic                  locked;
   logic                  set_stb;
   logic [set_addr_w-1:0] set_addr;
   logic [set_data_w-1:0] set_data;
   logic [n_radios-1:0]   run_rx;
   logic [n_radios-1:0]   run_tx;
   logic                  ready;
   logic                  codec_reset;
   logic [atr_w-1:0]      fe1_ctrl;
   logic [atr_w-1:0]      fe2_ctrl;
   logic                  tx_bandsel_a;
   logic                  tx_bandsel_b;
   logic                  rx_bandsel_a;
   logic                  rx_bandsel_b;
   logic                  rx_bandsel_c;
   logic                  mimo;
   logic                  ref_sel;

   integer                seed;
   logic                  checking;          // Assertions armed
   int                    errors   = 0;
   int                    timeouts = 0;
   int                    rel_cycles;        // Released edges since reset or lock loss
   logic                  model_ready;
   logic [set_data_w-1:0] m_misc;            // Shadow of the misc register
   logic [set_data_w-1:0] m_misc_r;          // One stage nearer the pins
   logic [atr_w-1:0]      m_word [n_radios][4];
   logic [atr_w-1:0]      m_atr  [n_radios];  // Word each radio drives
   int                    atr_off;
   logic                  atr_hit;
   logic [atr_w-1:0]      exp_fe1;
   logic [atr_w-1:0]      exp_fe2;
   logic [6:0]            pins;
   logic [6:0]            exp_pins;

   b200_fe_ctrl dut_i (
      .bus_clk      (bus_clk),
      .reset_global (reset_global),
      .locked       (locked),
      .set_stb      (set_stb),
      .set_addr     (set_addr),
      .set_data     (set_data),
      .run_rx       (run_rx),
      .run_tx       (run_tx),
      .ready        (ready),
      .codec_reset  (codec_reset),
      .fe1_ctrl     (fe1_ctrl),
      .fe2_ctrl     (fe2_ctrl),
      .tx_bandsel_a (tx_bandsel_a),
      .tx_bandsel_b (tx_bandsel_b),
      .rx_bandsel_a (rx_bandsel_a),
      .rx_bandsel_b (rx_bandsel_b),
      .rx_bandsel_c (rx_bandsel_c),
      .mimo         (mimo),
      .ref_sel      (ref_sel)
   );

   initial begin
      bus_clk = 1'b0;
      forever #10 bus_clk = ~bus_clk;  // 20 ns period
   end

   ////////////////////////////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////////////////////////////

   always @(posedge bus_clk or posedge reset_global or negedge locked) begin
      if (reset_global || !locked) begin
         rel_cycles <= 0;
      end else if (rel_cycles < ready_delay) begin
         rel_cycles <= rel_cycles + 1;  // Saturates once ready
      end
   end

   assign model_ready = (rel_cycles >= ready_delay);

   // Radio r, state s sits at base + 4*r + s
   assign atr_off = int'(set_addr) - int'(reg_atr_base);
   assign atr_hit = (atr_off >= 0) && (atr_off < atr_words);

   always @(posedge bus_clk or posedge reset_global or negedge locked) begin
      if (reset_global || !locked || !model_ready) begin
         m_misc   <= '0;
         m_misc_r <= '0;
         for (int r = 0; r < n_radios; r++) begin
            m_atr[r] <= '0;
            for (int s = 0; s < 4; s++) begin
               m_word[r][s] <= '0;
            end
         end
      end else begin
         if (set_stb && (set_addr == reg_misc_outs)) begin
            m_misc <= set_data;
         end
         if (set_stb && atr_hit) begin
            m_word[atr_off / 4][atr_off % 4] <= set_data[atr_w-1:0];
         end
         m_misc_r <= m_misc;
         // Idle 0, rx only 1, tx only 2, both 3
         for (int r = 0; r < n_radios; r++) begin
            m_atr[r] <= m_word[r][(run_tx[r] ? 2 : 0) + (run_rx[r] ? 1 : 0)];
         end
      end
   end

   // Swap bit high keeps radio 0 on frontend 1
   assign exp_fe1 = m_misc_r[misc_bit_swap_atr_n] ? m_atr[0] : m_atr[1];
   assign exp_fe2 = m_misc_r[misc_bit_swap_atr_n] ? m_atr[1] : m_atr[0];

   assign pins = {tx_bandsel_a, tx_bandsel_b, rx_bandsel_a, rx_bandsel_b,
                  rx_bandsel_c, mimo, ref_sel};
   assign exp_pins = {m_misc_r[misc_bit_tx_bandsel_a], m_misc_r[misc_bit_tx_bandsel_b],
                      m_misc_r[misc_bit_rx_bandsel_a], m_misc_r[misc_bit_rx_bandsel_b],
                      m_misc_r[misc_bit_rx_bandsel_c], m_misc_r[misc_bit_mimo],
                      m_misc_r[misc_bit_ref_sel]};

   ////////////////////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////////////////////

   task automatic report_mismatch(input string what, input logic [31:0] got,
                                  input logic [31:0] exp);
      errors++;
      $display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
   endtask

   a_ready : assert property (@(posedge bus_clk) disable iff (!checking)
      ready == model_ready)
      else report_mismatch("ready", 32'(ready), 32'(model_ready));

   a_codec_reset : assert property (@(posedge bus_clk) disable iff (!checking)
      codec_reset == !reset_global)
      else report_mismatch("codec_reset", 32'(codec_reset), 32'(!reset_global));

   a_quiet : assert property (@(posedge bus_clk) disable iff (!checking)
      !ready |-> (fe1_ctrl == '0) && (fe2_ctrl == '0) && (pins == '0))
      else report_mismatch("pins in reset", {fe1_ctrl, fe2_ctrl, 9'd0, pins}, '0);

   a_fe1 : assert property (@(posedge bus_clk) disable iff (!checking)
      fe1_ctrl == exp_fe1)
      else report_mismatch("fe1_ctrl", 32'(fe1_ctrl), 32'(exp_fe1));

   a_fe2 : assert property (@(posedge bus_clk) disable iff (!checking)
      fe2_ctrl == exp_fe2)
      else report_mismatch("fe2_ctrl", 32'(fe2_ctrl), 32'(exp_fe2));

   a_misc_pins : assert property (@(posedge bus_clk) disable iff (!checking)
      pins == exp_pins)
      else report_mismatch("misc pins", 32'(pins), 32'(exp_pins));

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////////////////////

   task automatic idle_cycles(input int n);
      repeat (n) @(posedge bus_clk);
      #2;  // Inputs change just after the edge
   endtask

   task automatic write_reg(input logic [set_addr_w-1:0] addr,
                            input logic [set_data_w-1:0] data);
      set_stb  = 1'b1;
      set_addr = addr;
      set_data = data;
      idle_cycles(1);
      set_stb  = 1'b0;
   endtask

   task automatic wait_ready();
      int cycles;
      cycles = 0;
      while (!ready && (cycles < ready_timeout)) begin
         idle_cycles(1);
         cycles++;
      end
      if (!ready) begin
         timeouts++;
         $display("Timeout at %0t: ready stayed low for %0d bus clocks", $time, cycles);
      end
   endtask

   initial begin
      seed         = 32'h2ce9;
      checking     = 1'b0;
      reset_global = 1'b1;
      locked       = 1'b1;  // Generator output settles on its first edge
      set_stb      = 1'b0;
      set_addr     = '0;
      set_data     = '0;
      run_rx       = '0;
      run_tx       = '0;

      // Reset for 4 cycles, lock comes after it
      idle_cycles(1);
      locked   = 1'b0;
      checking = 1'b1;
      idle_cycles(3);
      reset_global = 1'b0;
      idle_cycles(2);
      locked = 1'b1;
      wait_ready();

      // Misc decode, then writes that hit nothing
      for (int i = 0; i < 6; i++) begin
         write_reg(reg_misc_outs, $random(seed));
         idle_cycles(2);
      end
      write_reg(8'h01, $random(seed));
      write_reg(8'h0f, $random(seed));
      write_reg(reg_atr_base + 8'(atr_words), $random(seed));
      write_reg(8'hff, $random(seed));
      idle_cycles(3);

      // ATR words for every radio and state
      for (int r = 0; r < n_radios; r++) begin
         for (int s = 0; s < 4; s++) begin
            write_reg(reg_atr_base + 8'(4 * r + s), $random(seed));
         end
      end
      for (int c = 0; c < 16; c++) begin
         {run_tx, run_rx} = 4'(c);  // All state pairs of both radios
         idle_cycles(2);
      end

      // Swap, radio 0 receiving and radio 1 transmitting
      run_rx = 2'b01;
      run_tx = 2'b10;
      idle_cycles(2);
      write_reg(reg_misc_outs, 32'd1 << misc_bit_swap_atr_n);
      idle_cycles(3);
      write_reg(reg_misc_outs, 32'h0);
      idle_cycles(3);
      write_reg(reg_misc_outs, 32'h1ff);
      idle_cycles(3);

      // Lock lost mid-run
      run_rx = 2'b11;
      run_tx = 2'b01;
      idle_cycles(2);
      locked = 1'b0;
      idle_cycles(3);
      write_reg(reg_misc_outs, 32'h1ff);  // Lands while still in reset
      locked = 1'b1;
      idle_cycles(4);
      write_reg(reg_atr_base + 8'd3, 32'hff);
      wait_ready();
      idle_cycles(4);
      // Radio 1 rx only word, shown on a frontend
      write_reg(reg_atr_base + 8'd5, $random(seed));  // Bank usable again
      idle_cycles(4);

      $display("Checks done: %0d errors, %0d timeouts", errors, timeouts);
      if ((errors == 0) && (timeouts == 0)) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule : tb_b200_fe_ctrl

//--- flist.f
b200_regs_pkg.sv
b200_fe_pkg.sv
clocks_ready_reset.sv
settings_regs.sv
radio_atr_ctrl.sv
frontend_atr_mux.sv
b200_fe_ctrl.sv
tb_b200_fe_ctrl.sv

//--- run_sim.sh
#!/bin/sh
# Build the board-control testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 \
   --top-module tb_b200_fe_ctrl \
   -f flist.f \
   -o tb_b200_fe_ctrl

./obj_dir/tb_b200_fe_ctrl > sim.log 2>&1 || true
cat sim.log

if grep -qx "Everything OK" sim.log; then
   echo "Simulation passed"
   exit 0
else
   echo "Simulation failed, see sim.log"
   exit 1
fi
